/* Bender.yml */
package:
  name: rv_core

sources:
  - src/rv_pkg.sv
  - src/rv_regfile.sv
  - src/rv_alu.sv
  - src/rv_divider.sv
  - src/rv_sequencer.sv
  - src/rv_core.sv
  - target: simulation
    files:
      - tb/tb_mem_model.sv
      - tb/tb_rv_core.sv

/* compile.f */
src/rv_pkg.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_divider.sv
src/rv_sequencer.sv
src/rv_core.sv
tb/tb_mem_model.sv
tb/tb_rv_core.sv

/* src/rv_alu.sv */
// single-cycle ALU shared by register, immediate, address and branch-compare operations
`timescale 1ns/1ps

module rv_alu (
    input  rv_pkg::xlen_t   alu_a,
    input  rv_pkg::xlen_t   alu_b,
    input  rv_pkg::alu_op_e alu_op,
    output rv_pkg::xlen_t   alu_result
);
    import rv_pkg::*;

    logic [4:0] shamt;

    // shifts only look at the low five bits
    assign shamt = alu_b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_result = alu_a + alu_b;
            ALU_SUB:  alu_result = alu_a - alu_b;
            ALU_AND:  alu_result = alu_a & alu_b;
            ALU_OR:   alu_result = alu_a | alu_b;
            ALU_XOR:  alu_result = alu_a ^ alu_b;
            ALU_SLL:  alu_result = alu_a << shamt;
            ALU_SRL:  alu_result = alu_a >> shamt;
            ALU_SLT:  alu_result = xlen_t'($signed(alu_a) < $signed(alu_b));
            ALU_SLTU: alu_result = xlen_t'(alu_a < alu_b);
            // low word of the product, as MUL defines it
            ALU_MUL:  alu_result = alu_a * alu_b;
            default:  alu_result = alu_a + alu_b;
        endcase
    end

endmodule

/* src/rv_core.sv */
// top level of the multi-cycle RV32 core, connecting sequencer, register file, ALU and divider
`timescale 1ns/1ps

module rv_core #(
    parameter rv_pkg::xlen_t OUT_ADDR  = 32'd1000,
    parameter rv_pkg::xlen_t HALT_ADDR = 32'd1004
) (
    input  logic          clk,
    input  logic          rst,
    output rv_pkg::xlen_t mem_addr,
    output rv_pkg::xlen_t mem_wr_data,
    output logic          mem_rd_req,
    output logic          mem_wr_req,
    input  rv_pkg::xlen_t mem_rd_data,
    input  logic          mem_ack,
    output rv_pkg::xlen_t out_data,
    output logic          out_valid,
    output logic          halted
);
    import rv_pkg::*;

    // register file port
    reg_sel_t rs1_sel, rs2_sel, wr_sel;
    xlen_t    rs1_data, rs2_data, wr_data;
    logic     wr_en;

    // ALU operands and result
    xlen_t    alu_a, alu_b, alu_result;
    alu_op_e  alu_op;

    // divider handshake and results
    logic     div_start, div_done;
    xlen_t    div_dividend, div_divisor;
    xlen_t    div_quot, div_rem;

    // the sequencer steers the datapath while ALU and divider work side by side
    rv_sequencer #(
        .OUT_ADDR  (OUT_ADDR),
        .HALT_ADDR (HALT_ADDR)
    ) u_sequencer (.*);

    rv_regfile u_regfile (.*);

    rv_alu u_alu (.*);

    rv_divider u_divider (.*);

endmodule

/* src/rv_divider.sv */
// serial restoring divider for DIVU and REMU, one quotient bit per clock after a start pulse
`timescale 1ns/1ps

module rv_divider (
    input  logic          clk,
    input  logic          rst,
    input  logic          div_start,
    input  rv_pkg::xlen_t div_dividend,
    input  rv_pkg::xlen_t div_divisor,
    output logic          div_done,
    output rv_pkg::xlen_t div_quot,
    output rv_pkg::xlen_t div_rem
);
    import rv_pkg::*;

    localparam int CNT_W = $clog2(XLEN + 1);

    logic [CNT_W-1:0] steps_left;
    xlen_t            divisor_q;
    logic [XLEN:0]    partial;
    logic [XLEN:0]    trial;

    // bring down the next dividend bit, then try the subtract
    assign partial = {div_rem, div_quot[XLEN-1]};
    assign trial   = partial - {1'b0, divisor_q};

    // done fires on the cycle after the last of the XLEN steps
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            steps_left <= '0;
            div_done   <= 1'b0;
        end else begin
            div_done <= 1'b0;
            if (div_start) begin
                steps_left <= CNT_W'(XLEN);
            end else if (steps_left != '0) begin
                steps_left <= steps_left - 1'b1;
                div_done   <= (steps_left == CNT_W'(1));
            end
        end
    end

    // quotient shifts in from the bottom as the dividend shifts out the top
    // a zero divisor never borrows and leaves all ones and the dividend
    always_ff @(posedge clk) begin
        if (div_start) begin
            divisor_q <= div_divisor;
            div_quot  <= div_dividend;
            div_rem   <= '0;
        end else if (steps_left != '0) begin
            if (trial[XLEN]) begin
                div_rem  <= partial[XLEN-1:0];
                div_quot <= {div_quot[XLEN-2:0], 1'b0};
            end else begin
                div_rem  <= trial[XLEN-1:0];
                div_quot <= {div_quot[XLEN-2:0], 1'b1};
            end
        end
    end

endmodule

/* src/rv_pkg.sv */
// shared widths, opcodes, ALU selectors and sequencer states, imported by the core and its testbench
package rv_pkg;

    // machine word and register file geometry
    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0]             xlen_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_sel_t;

    // every instruction is one word
    localparam xlen_t INSTR_STEP = 32'd4;

    // major opcodes of the supported RV32 subset
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT,
        ALU_SLTU,
        ALU_MUL
    } alu_op_e;

    // one instruction in flight, so a handful of states covers it
    typedef enum logic [2:0] {
        S_FETCH,
        S_WAIT_INSTR,
        S_WAIT_MEM,
        S_WAIT_DIV,
        S_HALTED
    } seq_state_e;

endpackage

/* src/rv_regfile.sv */
// 32-entry integer register file with two combinational reads and one clocked write port
`timescale 1ns/1ps

module rv_regfile (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::reg_sel_t rs1_sel,
    input  rv_pkg::reg_sel_t rs2_sel,
    input  rv_pkg::reg_sel_t wr_sel,
    input  logic             wr_en,
    input  rv_pkg::xlen_t    wr_data,
    output rv_pkg::xlen_t    rs1_data,
    output rv_pkg::xlen_t    rs2_data
);
    import rv_pkg::*;

    xlen_t regs [NUM_REGS];

    assign rs1_data = regs[rs1_sel];
    assign rs2_data = regs[rs2_sel];

    // x0 is cleared here and never written afterwards
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_sel != '0) begin
            regs[wr_sel] <= wr_data;
        end
    end

endmodule

/* src/rv_sequencer.sv */
// fetch/execute FSM of the core that decodes, drives the memory port and picks the writeback source
`timescale 1ns/1ps

module rv_sequencer #(
    parameter rv_pkg::xlen_t OUT_ADDR  = 32'd1000,
    parameter rv_pkg::xlen_t HALT_ADDR = 32'd1004
) (
    input  logic             clk,
    input  logic             rst,
    output rv_pkg::xlen_t    mem_addr,
    output rv_pkg::xlen_t    mem_wr_data,
    output logic             mem_rd_req,
    output logic             mem_wr_req,
    input  rv_pkg::xlen_t    mem_rd_data,
    input  logic             mem_ack,
    output rv_pkg::reg_sel_t rs1_sel,
    output rv_pkg::reg_sel_t rs2_sel,
    output rv_pkg::reg_sel_t wr_sel,
    input  rv_pkg::xlen_t    rs1_data,
    input  rv_pkg::xlen_t    rs2_data,
    output logic             wr_en,
    output rv_pkg::xlen_t    wr_data,
    output rv_pkg::xlen_t    alu_a,
    output rv_pkg::xlen_t    alu_b,
    output rv_pkg::alu_op_e  alu_op,
    input  rv_pkg::xlen_t    alu_result,
    output logic             div_start,
    output rv_pkg::xlen_t    div_dividend,
    output rv_pkg::xlen_t    div_divisor,
    input  logic             div_done,
    input  rv_pkg::xlen_t    div_quot,
    input  rv_pkg::xlen_t    div_rem,
    output rv_pkg::xlen_t    out_data,
    output logic             out_valid,
    output logic             halted
);
    import rv_pkg::*;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_DIVU = 3'b101;
    localparam logic [2:0] F3_REMU = 3'b111;
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_WORD = 3'b010;

    seq_state_e state, state_d;
    xlen_t      pc, pc_d, pc_plus4;
    xlen_t      instr_q, instr;
    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm_i, imm_s, imm_b, imm_u;
    alu_op_e    reg_op;
    logic       reg_op_ok, reg_op_div;
    logic       rd_req_d, wr_req_d;
    xlen_t      addr_d, wdata_d;

    // decode straight off the bus in the acknowledge cycle and from the latch afterwards
    assign instr    = (state == S_WAIT_INSTR) ? mem_rd_data : instr_q;
    assign opcode   = opcode_e'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign rs1_sel  = instr[19:15];
    assign rs2_sel  = instr[24:20];
    assign wr_sel   = instr[11:7];
    assign imm_i    = {{20{instr[31]}}, instr[31:20]};
    assign imm_s    = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b    = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u    = {instr[31:12], 12'b0};
    assign pc_plus4 = pc + INSTR_STEP;

    assign div_dividend = rs1_data;
    assign div_divisor  = rs2_data;
    assign out_data     = rs2_data;
    assign halted       = (state == S_HALTED);

    // SRA and anything else unlisted in the register group fall to default
    always_comb begin
        reg_op     = ALU_ADD;
        reg_op_ok  = 1'b1;
        reg_op_div = 1'b0;
        case ({funct7, funct3})
            {F7_BASE, F3_ADD}:    reg_op = ALU_ADD;
            {F7_ALT, F3_ADD}:     reg_op = ALU_SUB;
            {F7_BASE, F3_SLL}:    reg_op = ALU_SLL;
            {F7_BASE, F3_SLT}:    reg_op = ALU_SLT;
            {F7_BASE, F3_SLTU}:   reg_op = ALU_SLTU;
            {F7_BASE, F3_XOR}:    reg_op = ALU_XOR;
            {F7_BASE, F3_SRL}:    reg_op = ALU_SRL;
            {F7_BASE, F3_OR}:     reg_op = ALU_OR;
            {F7_BASE, F3_AND}:    reg_op = ALU_AND;
            {F7_MULDIV, F3_ADD}:  reg_op = ALU_MUL;
            {F7_MULDIV, F3_DIVU},
            {F7_MULDIV, F3_REMU}: reg_op_div = 1'b1;
            default:              reg_op_ok = 1'b0;
        endcase
    end

    always_comb begin
        state_d   = state;
        pc_d      = pc;
        rd_req_d  = mem_rd_req & ~mem_ack;
        wr_req_d  = mem_wr_req & ~mem_ack;
        addr_d    = mem_addr;
        wdata_d   = mem_wr_data;
        alu_a     = rs1_data;
        alu_b     = rs2_data;
        alu_op    = ALU_ADD;
        wr_en     = 1'b0;
        wr_data   = alu_result;
        div_start = 1'b0;
        out_valid = 1'b0;
        case (state)
            S_FETCH: begin
                rd_req_d = 1'b1;
                addr_d   = pc;
                state_d  = S_WAIT_INSTR;
            end
            S_WAIT_INSTR: begin
                if (mem_ack) begin
                    // pc moves on here and the wait states only finish the instruction
                    state_d = S_FETCH;
                    pc_d    = pc_plus4;
                    case (opcode)
                        OP_IMM: begin
                            alu_b = imm_i;
                            if (funct3 == F3_ADD) begin
                                wr_en = 1'b1;
                            end else begin
                                state_d = S_HALTED;
                            end
                        end
                        OP_REG: begin
                            alu_op = reg_op;
                            if (reg_op_div) begin
                                div_start = 1'b1;
                                state_d   = S_WAIT_DIV;
                            end else if (reg_op_ok) begin
                                wr_en = 1'b1;
                            end else begin
                                state_d = S_HALTED;
                            end
                        end
                        OP_LUI: begin
                            wr_en   = 1'b1;
                            wr_data = imm_u;
                        end
                        OP_AUIPC: begin
                            alu_a = pc;
                            alu_b = imm_u;
                            wr_en = 1'b1;
                        end
                        OP_BRANCH: begin
                            // compare through the ALU subtract
                            alu_op = ALU_SUB;
                            if (funct3 != F3_BEQ && funct3 != F3_BNE) begin
                                state_d = S_HALTED;
                            end else if ((alu_result == '0) == (funct3 == F3_BEQ)) begin
                                pc_d = pc + imm_b;
                            end
                        end
                        OP_LOAD: begin
                            alu_b = imm_i;
                            if (funct3 == F3_WORD) begin
                                rd_req_d = 1'b1;
                                addr_d   = alu_result;
                                state_d  = S_WAIT_MEM;
                            end else begin
                                state_d = S_HALTED;
                            end
                        end
                        OP_STORE: begin
                            alu_b = imm_s;
                            if (funct3 != F3_WORD || alu_result == HALT_ADDR) begin
                                state_d = S_HALTED;
                            end else if (alu_result == OUT_ADDR) begin
                                out_valid = 1'b1;
                            end else begin
                                wr_req_d = 1'b1;
                                addr_d   = alu_result;
                                wdata_d  = rs2_data;
                                state_d  = S_WAIT_MEM;
                            end
                        end
                        default: state_d = S_HALTED;
                    endcase
                end
            end
            S_WAIT_MEM: begin
                if (mem_ack) begin
                    state_d = S_FETCH;
                    if (opcode == OP_LOAD) begin
                        wr_en   = 1'b1;
                        wr_data = mem_rd_data;
                    end
                end
            end
            S_WAIT_DIV: begin
                if (div_done) begin
                    state_d = S_FETCH;
                    wr_en   = 1'b1;
                    wr_data = (funct3 == F3_REMU) ? div_rem : div_quot;
                end
            end
            // halted holds until reset
            default: state_d = S_HALTED;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= S_FETCH;
            pc         <= '0;
            mem_rd_req <= 1'b0;
            mem_wr_req <= 1'b0;
        end else begin
            state      <= state_d;
            pc         <= pc_d;
            mem_rd_req <= rd_req_d;
            mem_wr_req <= wr_req_d;
        end
    end

    always_ff @(posedge clk) begin
        mem_addr    <= addr_d;
        mem_wr_data <= wdata_d;
        if (state == S_WAIT_INSTR && mem_ack) begin
            instr_q <= mem_rd_data;
        end
    end

endmodule

/* tb/tb_mem_model.sv */
// behavioral word memory for the core testbench, acknowledging each request after 1 to 4 cycles
`timescale 1ns/1ps

module tb_mem_model #(
    parameter int SEED = 40533
) (
    input  logic          clk,
    input  logic          rst,
    input  rv_pkg::xlen_t mem_addr,
    input  rv_pkg::xlen_t mem_wr_data,
    input  logic          mem_rd_req,
    input  logic          mem_wr_req,
    output rv_pkg::xlen_t mem_rd_data,
    output logic          mem_ack
);
    import rv_pkg::*;

    // 256 words cover byte addresses 0 to 1023
    xlen_t      mem [256];
    integer     seed = SEED;
    logic       busy;
    logic [1:0] delay;

    initial begin
        mem_ack     = 1'b0;
        mem_rd_data = '0;
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            busy        <= 1'b0;
            delay       <= '0;
            mem_ack     <= 1'b0;
            mem_rd_data <= '0;
        end else begin
            mem_ack <= 1'b0;
            if (mem_ack) begin
                // the core replaces or drops its request on this edge
                busy <= 1'b0;
            end else if (!busy && (mem_rd_req || mem_wr_req)) begin
                busy  <= 1'b1;
                delay <= 2'($random(seed));
            end else if (busy && delay != '0) begin
                delay <= delay - 1'b1;
            end else if (busy) begin
                mem_ack <= 1'b1;
                if (mem_wr_req) begin
                    mem[mem_addr[9:2]] <= mem_wr_data;
                end else begin
                    mem_rd_data <= mem[mem_addr[9:2]];
                end
            end
        end
    end

endmodule

/* tb/tb_rv_core.sv */
// testbench top that runs small assembled programs on the RV32 core and checks its output strobe
`timescale 1ns/1ps

module tb_rv_core;
    import rv_pkg::*;

    localparam int OUT_ADDR  = 1000;
    localparam int HALT_ADDR = 1004;
    localparam int DATA_BASE = 768;
    localparam int HALT_WAIT = 4000;
    localparam int QUIET_CYC = 50;

    logic  clk;
    logic  rst;
    xlen_t mem_addr, mem_wr_data, mem_rd_data, out_data;
    logic  mem_rd_req, mem_wr_req, mem_ack, out_valid, halted;

    integer seed = 40533;
    int     errors = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    xlen_t  prog [$];
    xlen_t  expected [$];
    int     data_idx [$];
    xlen_t  data_val [$];
    int     reset_age = 0;
    logic   just_released = 1'b0;
    logic   await_first = 1'b0;

    rv_core u_rv_core (.*);

    tb_mem_model u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic xlen_t r_type(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OP_REG};
    endfunction

    function automatic xlen_t i_type(int imm, int rs1, logic [2:0] f3, int rd, opcode_e op);
        return {12'(imm), 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic xlen_t s_type(int imm, int rs2, int rs1);
        logic [11:0] im;
        im = 12'(imm);
        return {im[11:5], 5'(rs2), 5'(rs1), 3'b010, im[4:0], OP_STORE};
    endfunction

    function automatic xlen_t b_type(int imm, int rs2, int rs1, logic [2:0] f3);
        logic [12:0] im;
        im = 13'(imm);
        return {im[12], im[10:5], 5'(rs2), 5'(rs1), f3, im[4:1], im[11], OP_BRANCH};
    endfunction

    function automatic xlen_t u_type(xlen_t imm, int rd, opcode_e op);
        return {imm[31:12], 5'(rd), op};
    endfunction

    task automatic put(xlen_t word);
        prog.push_back(word);
    endtask

    // lui then addi with the upper part rounded up for a sign-extended low half
    task automatic set_reg(int rd, xlen_t value);
        put(u_type(value + 32'h800, rd, OP_LUI));
        put(i_type(int'(value[11:0]), rd, 3'b000, rd, OP_IMM));
    endtask

    task automatic emit(int rs, xlen_t value);
        put(s_type(OUT_ADDR, rs, 0));
        expected.push_back(value);
    endtask

    task automatic alu_case(logic [6:0] f7, logic [2:0] f3, xlen_t value);
        put(r_type(f7, 2, 1, f3, 3));
        emit(3, value);
    endtask

    task automatic fail_value(string what, xlen_t got, xlen_t want);
        errors++;
        $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, want);
    endtask

    task automatic fail_plain(string what);
        errors++;
        $display("Failure at %0t ns: %s", $time, what);
    endtask

    always @(posedge clk) begin
        if ((rst && reset_age > 0) || just_released) begin
            assert (!out_valid && !halted && !mem_rd_req && !mem_wr_req)
            else fail_plain("a strobe, halt or memory request is active around reset");
        end
        if (!rst && await_first && (mem_rd_req || mem_wr_req)) begin
            assert (mem_rd_req && !mem_wr_req && mem_addr == '0)
            else fail_plain("the first request after reset is not a read at address 0");
            await_first = 1'b0;
        end
        if (!rst && halted) begin
            assert (!out_valid && !mem_rd_req && !mem_wr_req)
            else fail_plain("the core is still active after halting");
        end
        if (!rst && out_valid) begin
            assert (expected.size() != 0)
            else fail_plain("the core emitted a value that the program does not produce");
            if (expected.size() != 0) begin
                assert (out_data == expected[0])
                else fail_value("out_data", out_data, expected[0]);
                void'(expected.pop_front());
            end
        end
        if (rst) begin
            await_first = 1'b1;
            reset_age++;
        end else begin
            reset_age = 0;
        end
        just_released = rst;
    end

    // reset, load, release, then wait for the halt and a quiet stretch
    task automatic run_program(string name);
        int   err_before;
        int   cyc;
        logic halt_seen;
        err_before = errors;
        @(posedge clk);
        rst <= 1'b1;
        repeat (8) @(posedge clk);
        for (int i = 0; i < 256; i++) begin
            u_mem.mem[i] = {8'hee, 8'(i), ~8'(i), 8'(i)};
        end
        foreach (prog[i]) begin
            u_mem.mem[i] = prog[i];
        end
        foreach (data_idx[i]) begin
            u_mem.mem[data_idx[i]] = data_val[i];
        end
        rst <= 1'b0;
        cyc = 0;
        while (!halted && cyc < HALT_WAIT) begin
            @(posedge clk);
            cyc++;
        end
        halt_seen = halted;
        if (!halt_seen) begin
            fail_plain($sformatf("test %s timed out waiting for the core to halt", name));
        end
        cyc = 0;
        while (cyc < QUIET_CYC) begin
            @(posedge clk);
            cyc++;
            // halted is a level that only reset clears
            if (halt_seen) begin
                assert (halted)
                else fail_plain("halted fell before the next reset");
            end
        end
        assert (expected.size() == 0)
        else fail_plain($sformatf("%0d expected values were never emitted", expected.size()));
        tests_run++;
        if (errors != err_before) begin
            tests_failed++;
        end
        $display("test %s: %s", name, (errors == err_before) ? "ok" : "failed");
        prog.delete();
        expected.delete();
        data_idx.delete();
        data_val.delete();
    endtask

    task automatic test_alu();
        xlen_t a, b, base;
        a = $random(seed);
        b = $random(seed);
        set_reg(1, a);
        set_reg(2, b);
        emit(1, a);
        emit(2, b);
        put(i_type(-5, 1, 3'b000, 3, OP_IMM));
        emit(3, a - 32'd5);
        base = xlen_t'(prog.size() * 4);
        put(u_type(32'h1234_5000, 3, OP_AUIPC));
        emit(3, base + 32'h1234_5000);
        alu_case(7'h00, 3'b000, a + b);
        alu_case(7'h20, 3'b000, a - b);
        alu_case(7'h00, 3'b111, a & b);
        alu_case(7'h00, 3'b110, a | b);
        alu_case(7'h00, 3'b100, a ^ b);
        alu_case(7'h00, 3'b001, a << b[4:0]);
        alu_case(7'h00, 3'b101, a >> b[4:0]);
        // with different signs the negative operand is the smaller one
        alu_case(7'h00, 3'b010, (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b});
        alu_case(7'h00, 3'b011, {31'b0, a < b});
        alu_case(7'h01, 3'b000, a * b);
        // -3 against 5 separates signed from unsigned compare
        set_reg(1, -3);
        set_reg(2, 5);
        alu_case(7'h00, 3'b010, 32'd1);
        alu_case(7'h00, 3'b011, 32'd0);
        // writes to x0 are dropped
        put(i_type(123, 0, 3'b000, 0, OP_IMM));
        put(r_type(7'h00, 2, 1, 3'b000, 0));
        emit(0, '0);
        put(s_type(HALT_ADDR, 0, 0));
        run_program("alu");
    endtask

    task automatic test_mem();
        xlen_t vals [4];
        for (int k = 0; k < 4; k++) begin
            vals[k] = $random(seed);
            set_reg(1, vals[k]);
            put(s_type(DATA_BASE + 4 * k, 1, 0));
        end
        for (int k = 0; k < 4; k++) begin
            put(i_type(DATA_BASE + 4 * k, 0, 3'b010, 2, OP_LOAD));
            emit(2, vals[k]);
        end
        put(s_type(HALT_ADDR, 0, 0));
        run_program("mem");
    endtask

    task automatic test_div();
        xlen_t n, d;
        int    addr;
        for (int k = 0; k < 5; k++) begin
            n = $random(seed);
            d = (k == 0) ? '0 : xlen_t'($random(seed)) >> (6 * k);
            addr = DATA_BASE + 64 + 8 * k;
            data_idx.push_back(addr / 4);
            data_val.push_back(n);
            data_idx.push_back(addr / 4 + 1);
            data_val.push_back(d);
            put(i_type(addr, 0, 3'b010, 1, OP_LOAD));
            put(i_type(addr + 4, 0, 3'b010, 2, OP_LOAD));
            alu_case(7'h01, 3'b101, (d == '0) ? '1 : n / d);
            alu_case(7'h01, 3'b111, (d == '0) ? n : n % d);
        end
        put(s_type(HALT_ADDR, 0, 0));
        run_program("div");
    endtask

    task automatic test_loop();
        int n;
        n = 1 + ($unsigned($random(seed)) % 10);
        put(i_type(n, 0, 3'b000, 1, OP_IMM));
        put(i_type(0, 0, 3'b000, 2, OP_IMM));
        put(i_type(1, 2, 3'b000, 2, OP_IMM));
        put(i_type(-1, 1, 3'b000, 1, OP_IMM));
        put(b_type(12, 0, 1, 3'b000));
        put(b_type(-12, 0, 1, 3'b001));
        // only a broken branch falls through to this store
        put(s_type(OUT_ADDR, 0, 0));
        emit(2, xlen_t'(n));
        put(s_type(HALT_ADDR, 0, 0));
        run_program("loop");
    endtask

    task automatic test_halt();
        xlen_t v;
        v = $random(seed);
        set_reg(1, v);
        emit(1, v);
        put(s_type(HALT_ADDR, 0, 0));
        put(s_type(OUT_ADDR, 1, 0));
        put(s_type(DATA_BASE, 1, 0));
        run_program("halt");
    endtask

    initial begin
        rst = 1'b1;
        put(s_type(HALT_ADDR, 0, 0));
        run_program("reset");
        test_alu();
        test_mem();
        test_div();
        test_loop();
        test_halt();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
